//--- ti_rx_pkg.sv
package ti_rx_pkg;

    localparam int NADC    = 8;
    localparam int NTI     = 4;
    localparam int NTI_REP = 2;
    localparam int NPI     = 9;
    localparam int NOFS    = 8;
    localparam int NSLICE  = NTI + NTI_REP;

    // Host port
    localparam int REG_AW     = 6;
    localparam int REG_DW     = 16;
    localparam int NMEM_WORDS = 4;

    typedef struct packed {
        logic [NTI-1:0][NADC-1:0] mag;
        logic [NTI-1:0]           sign;
    } adc_frame_t;

    typedef struct packed {
        logic [NTI_REP-1:0][NADC-1:0] mag;
        logic [NTI_REP-1:0]           sign;
    } rep_frame_t;

    typedef logic signed [NADC:0] sample_t;

    // Main slices low, replicas high
    typedef sample_t [NSLICE-1:0] unf_frame_t;

    typedef struct packed {
        logic                        en_cal;
        logic                        en_cal_rep;
        logic                        en_ext_ofs;
        logic                        en_ext_ofs_rep;
        logic [3:0]                  navg;
        logic [NSLICE-1:0][NOFS-1:0] ext_ofs;
        logic [NPI-1:0]              pi_offset;
        logic                        cdr_freeze;
    } rx_cfg_t;

    typedef struct packed {
        logic [NSLICE-1:0][NOFS-1:0] pfd_ofs;
        logic [NSLICE-1:0]           cal_done;
        logic [NPI-1:0]              pi_ctl;
        logic                        dump_busy;
        logic                        dump_done;
        unf_frame_t                  mem_rdata;
    } rx_status_t;

    // Writable
    localparam logic [REG_AW-1:0] REG_CTRL      = 6'h00;
    localparam logic [REG_AW-1:0] REG_EXT_OFS0  = 6'h01;
    localparam logic [REG_AW-1:0] REG_PI_OFS    = 6'h07;
    localparam logic [REG_AW-1:0] REG_MEM_ADDR  = 6'h08;
    // Read only
    localparam logic [REG_AW-1:0] REG_STATUS    = 6'h10;
    localparam logic [REG_AW-1:0] REG_PFD_OFS0  = 6'h11;
    localparam logic [REG_AW-1:0] REG_PI_CTL    = 6'h17;
    localparam logic [REG_AW-1:0] REG_MEM_DATA0 = 6'h18;

endpackage

//--- ti_adc_retimer.sv
`timescale 1ns/1ps

module ti_adc_retimer #(
    parameter type frame_t = logic
) (
    input  logic   clk_adc,
    input  logic   reset_i,
    input  frame_t in_data_i,
    output frame_t out_data_o
);

    frame_t capture_q;

    // Capture stage absorbs the slice-to-slice skew of the front end
    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            capture_q <= '0;
        end else begin
            capture_q <= in_data_i;
        end
    end

    // Parallel output stage, all slices on one edge
    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            out_data_o <= '0;
        end else begin
            out_data_o <= capture_q;
        end
    end

endmodule

//--- adc_unfolding.sv
`timescale 1ns/1ps

module adc_unfolding import ti_rx_pkg::*; #(
    parameter int NAVG_MAX = 10
) (
    input  logic                   clk_adc,
    input  logic                   reset_i,
    input  logic [NADC-1:0]        din_i,
    input  logic                   sign_i,
    input  logic                   en_cal_i,
    input  logic                   en_ext_ofs_i,
    input  logic [3:0]             navg_i,
    input  logic signed [NOFS-1:0] ext_ofs_i,
    output sample_t                dout_o,
    output logic signed [NOFS-1:0] pfd_ofs_o,
    output logic                   cal_done_o
);

    localparam int ACC_W   = NADC + 1 + NAVG_MAX;
    localparam int SMP_MAX = 2**NADC - 1;
    localparam int SMP_MIN = -(2**NADC);
    localparam int OFS_MAX = 2**(NOFS-1) - 1;
    localparam int OFS_MIN = -(2**(NOFS-1));

    sample_t                 raw;
    logic signed [NOFS-1:0]  ofs_q;
    logic signed [NOFS-1:0]  ofs_sel;
    logic signed [NOFS-1:0]  ofs_cal;
    logic signed [NADC+1:0]  diff;
    logic signed [ACC_W-1:0] acc_q;
    logic signed [ACC_W-1:0] acc_next;
    logic signed [ACC_W-1:0] avg;
    logic [NAVG_MAX-1:0]     cnt_q;
    logic [3:0]              navg_eff;
    logic                    win_end;

    // Sign bit set means positive
    assign raw = sign_i ? sample_t'({1'b0, din_i}) : -sample_t'({1'b0, din_i});

    assign ofs_sel = en_ext_ofs_i ? ext_ofs_i : ofs_q;
    assign diff    = raw - ofs_sel;

    always_ff @(posedge clk_adc) begin
        if (diff > SMP_MAX) begin
            dout_o <= sample_t'(SMP_MAX);
        end else if (diff < SMP_MIN) begin
            dout_o <= sample_t'(SMP_MIN);
        end else begin
            dout_o <= sample_t'(diff);
        end
    end

    // Averaging window of 2^navg samples
    assign navg_eff = (navg_i > 4'(NAVG_MAX)) ? 4'(NAVG_MAX) : navg_i;
    assign win_end  = (cnt_q == NAVG_MAX'((1 << navg_eff) - 1));
    assign acc_next = acc_q + raw;
    assign avg      = acc_next >>> navg_eff;

    always_comb begin
        if (avg > OFS_MAX) begin
            ofs_cal = NOFS'(OFS_MAX);
        end else if (avg < OFS_MIN) begin
            ofs_cal = NOFS'(OFS_MIN);
        end else begin
            ofs_cal = avg[NOFS-1:0];
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            ofs_q      <= '0;
            acc_q      <= '0;
            cnt_q      <= '0;
            cal_done_o <= 1'b0;
        end else if (en_ext_ofs_i) begin
            ofs_q      <= ext_ofs_i;
            acc_q      <= '0;
            cnt_q      <= '0;
            cal_done_o <= 1'b0;
        end else if (en_cal_i) begin
            if (win_end) begin
                ofs_q      <= ofs_cal;
                acc_q      <= '0;
                cnt_q      <= '0;
                cal_done_o <= 1'b1;
            end else begin
                acc_q <= acc_next;
                cnt_q <= cnt_q + 1'b1;
            end
        end else begin
            // Offset holds, next enable starts a fresh window
            acc_q      <= '0;
            cnt_q      <= '0;
            cal_done_o <= 1'b0;
        end
    end

    assign pfd_ofs_o = ofs_q;

endmodule

//--- mm_cdr.sv
`timescale 1ns/1ps

module mm_cdr import ti_rx_pkg::*; (
    input  logic              clk_adc,
    input  logic              reset_i,
    input  sample_t [NTI-1:0] din_i,
    input  logic              freeze_i,
    input  logic [NPI-1:0]    pi_offset_i,
    output logic [NPI-1:0]    pi_ctl_o
);

    // Room for NTI terms of two samples each
    localparam int ERR_W = NADC + 5;

    sample_t                 prev_q;
    sample_t                 d_ext [NTI+1];
    logic signed [ERR_W-1:0] err_c;
    logic signed [ERR_W-1:0] err_q;
    logic [NPI-1:0]          pi_acc_q;

    // sign(s) * v, with sign(0) = 0
    function automatic logic signed [ERR_W-1:0] sgn_mul(sample_t s, sample_t v);
        if (s > 0) begin
            return ERR_W'(v);
        end else if (s < 0) begin
            return -ERR_W'(v);
        end
        return '0;
    endfunction

    always_comb begin
        d_ext[0] = prev_q;
        for (int k = 0; k < NTI; k++) begin
            d_ext[k+1] = din_i[k];
        end
        err_c = '0;
        // d_ext[k] is the earlier neighbor of d_ext[k+1]
        for (int k = 0; k < NTI; k++) begin
            err_c = err_c + sgn_mul(d_ext[k], d_ext[k+1]) - sgn_mul(d_ext[k+1], d_ext[k]);
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            prev_q <= '0;
            err_q  <= '0;
        end else begin
            prev_q <= din_i[NTI-1];
            err_q  <= err_c;
        end
    end

    // Sign integrator, wraps modulo 2^NPI
    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            pi_acc_q <= '0;
        end else if (!freeze_i) begin
            if (err_q > 0) begin
                pi_acc_q <= pi_acc_q + 1'b1;
            end else if (err_q < 0) begin
                pi_acc_q <= pi_acc_q - 1'b1;
            end
        end
    end

    assign pi_ctl_o = pi_acc_q + pi_offset_i;

endmodule

//--- oneshot_memory.sv
`timescale 1ns/1ps

module oneshot_memory import ti_rx_pkg::*; #(
    parameter int MEM_DEPTH = 16
) (
    input  logic                         clk_adc,
    input  logic                         reset_i,
    input  unf_frame_t                   in_data_i,
    input  logic                         start_i,
    input  logic [$clog2(MEM_DEPTH)-1:0] rd_addr_i,
    output unf_frame_t                   rd_data_o,
    output logic                         busy_o,
    output logic                         done_o
);

    localparam int AW = $clog2(MEM_DEPTH);

    unf_frame_t    mem [MEM_DEPTH];
    logic          start_q;
    logic          launch;
    logic          wr_en;
    logic [AW-1:0] wr_addr_q;
    logic [AW-1:0] wr_ptr;

    // Rising edge while idle, later pulses are ignored until the dump ends
    assign launch = start_i && !start_q && !busy_o;

    // First frame goes in on the launch cycle itself
    assign wr_en  = launch || busy_o;
    assign wr_ptr = busy_o ? wr_addr_q : '0;

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            start_q   <= 1'b0;
            busy_o    <= 1'b0;
            done_o    <= 1'b0;
            wr_addr_q <= '0;
        end else begin
            start_q <= start_i;
            if (launch) begin
                busy_o    <= 1'b1;
                done_o    <= 1'b0;
                wr_addr_q <= AW'(1);
            end else if (busy_o) begin
                if (wr_addr_q == AW'(MEM_DEPTH - 1)) begin
                    busy_o    <= 1'b0;
                    done_o    <= 1'b1;
                    wr_addr_q <= '0;
                end else begin
                    wr_addr_q <= wr_addr_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data_i;
        end
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

//--- rx_cfg_regs.sv
`timescale 1ns/1ps

module rx_cfg_regs import ti_rx_pkg::*; #(
    parameter int MEM_DEPTH = 16,
    parameter int NAVG_MAX  = 10
) (
    input  logic                         clk_adc,
    input  logic                         reset_i,
    input  logic                         host_req_i,
    input  logic                         host_we_i,
    input  logic [REG_AW-1:0]            host_addr_i,
    input  logic [REG_DW-1:0]            host_wdata_i,
    output logic                         host_ack_o,
    output logic [REG_DW-1:0]            host_rdata_o,
    input  rx_status_t                   status_i,
    output rx_cfg_t                      cfg_o,
    output logic [$clog2(MEM_DEPTH)-1:0] mem_addr_o
);

    localparam int AW = $clog2(MEM_DEPTH);

    typedef enum logic {
        ST_IDLE,
        ST_ACK
    } hs_state_t;

    hs_state_t                     state_q;
    logic                          access;
    logic [REG_DW-1:0]             rdata_c;
    logic [NMEM_WORDS*REG_DW-1:0]  mem_pad;

    // One access per req, taken in idle only
    assign access     = (state_q == ST_IDLE) && host_req_i;
    assign host_ack_o = (state_q == ST_ACK);

    always_comb begin
        mem_pad = '0;
        mem_pad[$bits(unf_frame_t)-1:0] = status_i.mem_rdata;
        rdata_c = '0;
        case (host_addr_i)
            REG_CTRL:     rdata_c = {7'b0, cfg_o.cdr_freeze, cfg_o.navg, cfg_o.en_ext_ofs_rep,
                                     cfg_o.en_ext_ofs, cfg_o.en_cal_rep, cfg_o.en_cal};
            REG_PI_OFS:   rdata_c = REG_DW'(cfg_o.pi_offset);
            REG_MEM_ADDR: rdata_c = REG_DW'(mem_addr_o);
            REG_STATUS:   rdata_c = REG_DW'({status_i.dump_done, status_i.dump_busy,
                                             status_i.cal_done});
            REG_PI_CTL:   rdata_c = REG_DW'(status_i.pi_ctl);
            default:      rdata_c = '0;
        endcase
        for (int i = 0; i < NSLICE; i++) begin
            if (host_addr_i == REG_EXT_OFS0 + REG_AW'(i)) begin
                rdata_c = REG_DW'(cfg_o.ext_ofs[i]);
            end
            // Calibrated offsets read back sign extended
            if (host_addr_i == REG_PFD_OFS0 + REG_AW'(i)) begin
                rdata_c = REG_DW'(signed'(status_i.pfd_ofs[i]));
            end
        end
        for (int i = 0; i < NMEM_WORDS; i++) begin
            if (host_addr_i == REG_MEM_DATA0 + REG_AW'(i)) begin
                rdata_c = mem_pad[REG_DW*i +: REG_DW];
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            state_q    <= ST_IDLE;
            cfg_o      <= '0;
            mem_addr_o <= '0;
        end else if (access) begin
            state_q <= ST_ACK;
            if (host_we_i) begin
                case (host_addr_i)
                    REG_CTRL: begin
                        cfg_o.en_cal         <= host_wdata_i[0];
                        cfg_o.en_cal_rep     <= host_wdata_i[1];
                        cfg_o.en_ext_ofs     <= host_wdata_i[2];
                        cfg_o.en_ext_ofs_rep <= host_wdata_i[3];
                        cfg_o.navg           <= (host_wdata_i[7:4] > 4'(NAVG_MAX)) ?
                                                4'(NAVG_MAX) : host_wdata_i[7:4];
                        cfg_o.cdr_freeze     <= host_wdata_i[8];
                    end
                    REG_PI_OFS:   cfg_o.pi_offset <= host_wdata_i[NPI-1:0];
                    REG_MEM_ADDR: mem_addr_o      <= host_wdata_i[AW-1:0];
                    default: ;
                endcase
                for (int i = 0; i < NSLICE; i++) begin
                    if (host_addr_i == REG_EXT_OFS0 + REG_AW'(i)) begin
                        cfg_o.ext_ofs[i] <= host_wdata_i[NOFS-1:0];
                    end
                end
            end
        end else if (state_q == ST_ACK && !host_req_i) begin
            state_q <= ST_IDLE;
        end
    end

    // Read data valid together with ack
    always_ff @(posedge clk_adc) begin
        if (access) begin
            host_rdata_o <= rdata_c;
        end
    end

endmodule

//--- ti_rx_core.sv
`timescale 1ns/1ps

module ti_rx_core import ti_rx_pkg::*; #(
    parameter int MEM_DEPTH = 16,
    parameter int NAVG_MAX  = 10
) (
    input  logic              clk_adc,
    input  logic              reset_i,
    input  adc_frame_t        adcout_i,
    input  rep_frame_t        adcout_rep_i,
    input  logic              dump_start_i,
    input  logic              host_req_i,
    input  logic              host_we_i,
    input  logic [REG_AW-1:0] host_addr_i,
    input  logic [REG_DW-1:0] host_wdata_i,
    output logic              host_ack_o,
    output logic [REG_DW-1:0] host_rdata_o,
    output logic [NPI-1:0]    pi_ctl_o,
    output unf_frame_t        unf_o
);

    adc_frame_t                         adc_rt;
    rep_frame_t                         rep_rt;
    rx_cfg_t                            cfg;
    rx_status_t                         status;
    unf_frame_t                         mem_rdata;
    logic [$clog2(MEM_DEPTH)-1:0]       mem_addr;
    logic                               dump_busy;
    logic                               dump_done;
    logic [NSLICE-1:0][NADC-1:0]        slice_mag;
    logic [NSLICE-1:0]                  slice_sign;
    logic [NSLICE-1:0]                  slice_cal;
    logic [NSLICE-1:0]                  slice_ext;
    wire logic [NSLICE-1:0][NOFS-1:0]   pfd_ofs;
    wire logic [NSLICE-1:0]             cal_done;
    wire unf_frame_t                    unf;

    ti_adc_retimer #(.frame_t(adc_frame_t)) retimer_inst (
        .clk_adc    (clk_adc),
        .reset_i    (reset_i),
        .in_data_i  (adcout_i),
        .out_data_o (adc_rt)
    );

    ti_adc_retimer #(.frame_t(rep_frame_t)) retimer_rep_inst (
        .clk_adc    (clk_adc),
        .reset_i    (reset_i),
        .in_data_i  (adcout_rep_i),
        .out_data_o (rep_rt)
    );

    // Replica slices sit above the main ones
    assign slice_mag  = {rep_rt.mag, adc_rt.mag};
    assign slice_sign = {rep_rt.sign, adc_rt.sign};
    assign slice_cal  = {{NTI_REP{cfg.en_cal_rep}}, {NTI{cfg.en_cal}}};
    assign slice_ext  = {{NTI_REP{cfg.en_ext_ofs_rep}}, {NTI{cfg.en_ext_ofs}}};

    for (genvar k = 0; k < NSLICE; k++) begin : gen_unfold
        adc_unfolding #(.NAVG_MAX(NAVG_MAX)) unfold_inst (
            .clk_adc      (clk_adc),
            .reset_i      (reset_i),
            .din_i        (slice_mag[k]),
            .sign_i       (slice_sign[k]),
            .en_cal_i     (slice_cal[k]),
            .en_ext_ofs_i (slice_ext[k]),
            .navg_i       (cfg.navg),
            .ext_ofs_i    (cfg.ext_ofs[k]),
            .dout_o       (unf[k]),
            .pfd_ofs_o    (pfd_ofs[k]),
            .cal_done_o   (cal_done[k])
        );
    end

    assign unf_o = unf;

    mm_cdr cdr_inst (
        .clk_adc     (clk_adc),
        .reset_i     (reset_i),
        .din_i       (unf[NTI-1:0]),
        .freeze_i    (cfg.cdr_freeze),
        .pi_offset_i (cfg.pi_offset),
        .pi_ctl_o    (pi_ctl_o)
    );

    oneshot_memory #(.MEM_DEPTH(MEM_DEPTH)) memory_inst (
        .clk_adc   (clk_adc),
        .reset_i   (reset_i),
        .in_data_i (unf),
        .start_i   (dump_start_i),
        .rd_addr_i (mem_addr),
        .rd_data_o (mem_rdata),
        .busy_o    (dump_busy),
        .done_o    (dump_done)
    );

    assign status = '{
        pfd_ofs:   pfd_ofs,
        cal_done:  cal_done,
        pi_ctl:    pi_ctl_o,
        dump_busy: dump_busy,
        dump_done: dump_done,
        mem_rdata: mem_rdata
    };

    rx_cfg_regs #(.MEM_DEPTH(MEM_DEPTH), .NAVG_MAX(NAVG_MAX)) regs_inst (
        .clk_adc      (clk_adc),
        .reset_i      (reset_i),
        .host_req_i   (host_req_i),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_ack_o   (host_ack_o),
        .host_rdata_o (host_rdata_o),
        .status_i     (status),
        .cfg_o        (cfg),
        .mem_addr_o   (mem_addr)
    );

endmodule

//--- ti_rx_core_asserts.sv
`timescale 1ns/1ps

module ti_rx_core_asserts (
    input logic clk_adc,
    input logic reset_i,
    input logic host_req_i,
    input logic host_ack_o,
    input logic dump_busy,
    input logic dump_done
);

    // Ack answers a request seen on the previous edge
    assert property (@(posedge clk_adc) disable iff (reset_i)
        $rose(host_ack_o) |-> $past(host_req_i))
        else $error("ack rose without a request");

    assert property (@(posedge clk_adc) disable iff (reset_i)
        host_ack_o && host_req_i |=> host_ack_o)
        else $error("ack dropped while req still high");

    assert property (@(posedge clk_adc) disable iff (reset_i)
        !(dump_busy && dump_done))
        else $error("dump busy and done high together");

endmodule

bind ti_rx_core ti_rx_core_asserts asserts_inst (
    .clk_adc    (clk_adc),
    .reset_i    (reset_i),
    .host_req_i (host_req_i),
    .host_ack_o (host_ack_o),
    .dump_busy  (dump_busy),
    .dump_done  (dump_done)
);

//--- tb_ti_rx_core.sv
`timescale 1ns/1ps

module tb_ti_rx_core import ti_rx_pkg::*; ();

    localparam int MEM_DEPTH   = 16;
    localparam int NAVG_MAX    = 10;
    localparam int ACK_TIMEOUT = 20;
    localparam int DONE_POLLS  = 50;

    logic              clk_adc;
    logic              reset_i;
    adc_frame_t        adcout;
    rep_frame_t        adcout_rep;
    logic              dump_start;
    logic              host_req;
    logic              host_we;
    logic [REG_AW-1:0] host_addr;
    logic [REG_DW-1:0] host_wdata;
    logic              host_ack;
    logic [REG_DW-1:0] host_rdata;
    logic [NPI-1:0]    pi_ctl;
    unf_frame_t        unf;

    // Shadow of the host configuration
    logic signed [NOFS-1:0] sh_ofs [NSLICE];
    logic                   sh_ext;
    logic                   sh_ext_rep;
    logic                   sh_freeze;
    logic [NPI-1:0]         sh_pi_ofs;

    // CDR reference model state
    int             m_prev;
    int             m_err_pipe [4];
    logic [NPI-1:0] m_acc;

    logic [31:0] lfsr_state;
    int          err_cnt;

    ti_rx_core #(.MEM_DEPTH(MEM_DEPTH), .NAVG_MAX(NAVG_MAX)) ti_rx_core_inst (
        .clk_adc      (clk_adc),
        .reset_i      (reset_i),
        .adcout_i     (adcout),
        .adcout_rep_i (adcout_rep),
        .dump_start_i (dump_start),
        .host_req_i   (host_req),
        .host_we_i    (host_we),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .host_ack_o   (host_ack),
        .host_rdata_o (host_rdata),
        .pi_ctl_o     (pi_ctl),
        .unf_o        (unf)
    );

    initial begin
        clk_adc = 1'b0;
        forever #5 clk_adc = ~clk_adc;
    end

    task automatic fail_now();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_sample(string name, sample_t got, sample_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_pi(string name, logic [NPI-1:0] got, logic [NPI-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_reg(string name, logic [REG_DW-1:0] got, logic [REG_DW-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_frame(string name, unf_frame_t got, unf_frame_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int sgn_of(int v);
        return (v > 0) ? 1 : ((v < 0) ? -1 : 0);
    endfunction

    // Sign bit 1 means positive before offset removal and 9-bit saturation
    function automatic sample_t unfold_model(logic [NADC-1:0] mag, logic s,
                                             logic signed [NOFS-1:0] ofs);
        int v;
        v = s ? int'(mag) : -int'(mag);
        v = v - int'(ofs);
        if (v > 255) v = 255;
        if (v < -256) v = -256;
        return sample_t'(v);
    endfunction

    function automatic unf_frame_t expected_frame();
        unf_frame_t f;
        for (int k = 0; k < NTI; k++) begin
            f[k] = unfold_model(adcout.mag[k], adcout.sign[k], sh_ofs[k]);
        end
        for (int k = 0; k < NTI_REP; k++) begin
            f[NTI+k] = unfold_model(adcout_rep.mag[k], adcout_rep.sign[k], sh_ofs[NTI+k]);
        end
        return f;
    endfunction

    // MM detector and sign integrator with zero offsets
    always @(posedge clk_adc) begin : cdr_model
        int u;
        int e;
        int prev;
        e = 0;
        prev = m_prev;
        for (int k = 0; k < NTI; k++) begin
            u = int'(unfold_model(adcout.mag[k], adcout.sign[k], '0));
            e = e + sgn_of(prev) * u - sgn_of(u) * prev;
            prev = u;
        end
        m_prev = prev;
        if (m_err_pipe[3] > 0) m_acc = m_acc + 1'b1;
        else if (m_err_pipe[3] < 0) m_acc = m_acc - 1'b1;
        m_err_pipe[3] = m_err_pipe[2];
        m_err_pipe[2] = m_err_pipe[1];
        m_err_pipe[1] = m_err_pipe[0];
        m_err_pipe[0] = e;
    end

    task automatic set_random_frame();
        for (int k = 0; k < NTI; k++) adcout.mag[k] = rand_bits(NADC);
        adcout.sign = rand_bits(NTI);
        for (int k = 0; k < NTI_REP; k++) adcout_rep.mag[k] = rand_bits(NADC);
        adcout_rep.sign = rand_bits(NTI_REP);
    endtask

    task automatic wait_ack(logic level);
        int t;
        t = 0;
        while (host_ack !== level) begin
            @(posedge clk_adc);
            #1;
            t++;
            if (t > ACK_TIMEOUT) begin
                $display("Timeout waiting for host ack to become %0d", level);
                fail_now();
            end
        end
    endtask

    task automatic host_access(logic we, logic [REG_AW-1:0] addr, logic [REG_DW-1:0] wdata,
                               output logic [REG_DW-1:0] rdata);
        wait_ack(1'b0);
        @(posedge clk_adc);
        #1;
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        wait_ack(1'b1);
        rdata    = host_rdata;
        host_req = 1'b0;
        host_we  = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic host_write(logic [REG_AW-1:0] addr, logic [REG_DW-1:0] data);
        logic [REG_DW-1:0] unused;
        host_access(1'b1, addr, data, unused);
        if (addr == REG_CTRL) begin
            sh_ext     = data[2];
            sh_ext_rep = data[3];
            sh_freeze  = data[8];
        end
        if (addr == REG_PI_OFS) sh_pi_ofs = data[NPI-1:0];
        if (addr >= REG_EXT_OFS0 && addr < REG_EXT_OFS0 + NSLICE) begin
            sh_ofs[addr - REG_EXT_OFS0] = data[NOFS-1:0];
        end
    endtask

    task automatic run_cdr(int cycles);
        logic [NPI-1:0] hold;
        @(posedge clk_adc);
        #1;
        hold = pi_ctl;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk_adc);
            #1;
            if (sh_freeze) check_pi("pi_ctl_o", pi_ctl, hold);
            else check_pi("pi_ctl_o", pi_ctl, m_acc + sh_pi_ofs);
            set_random_frame();
        end
    endtask

    task automatic run_dump();
        unf_frame_t        hist [$];
        logic [63:0]       word;
        logic [REG_DW-1:0] rd;
        int                polls;
        if (!sh_ext || !sh_ext_rep) begin
            $display("Dump check needs external offsets enabled on all slices");
            fail_now();
        end
        // Start pulse on step 4 and a second pulse on step 8 inside the busy window
        for (int i = 0; i < MEM_DEPTH + 6; i++) begin
            @(posedge clk_adc);
            #1;
            set_random_frame();
            dump_start = (i == 4) || (i == 8);
            hist.push_back(expected_frame());
        end
        dump_start = 1'b0;
        polls = 0;
        rd = '0;
        while (!rd[7]) begin
            host_access(1'b0, REG_STATUS, '0, rd);
            polls++;
            if (polls > DONE_POLLS) begin
                $display("Timeout waiting for dump_done");
                fail_now();
            end
        end
        // Slot 0 holds what unf_o showed while the start pulse was high
        for (int j = 0; j < MEM_DEPTH; j++) begin
            host_write(REG_MEM_ADDR, REG_DW'(j));
            word = '0;
            for (int w = 0; w < NMEM_WORDS; w++) begin
                host_access(1'b0, REG_MEM_DATA0 + REG_AW'(w), '0, rd);
                word[16*w +: 16] = rd;
            end
            check_frame($sformatf("mem[%0d]", j), word[$bits(unf_frame_t)-1:0], hist[1+j]);
        end
    endtask

    initial begin
        int                fd;
        int                n;
        int                a;
        int                d;
        int                f [8];
        int                cycles;
        logic [7:0]        cmd;
        string             line;
        logic [REG_DW-1:0] rd;
        unf_frame_t        exp_f;

        reset_i    = 1'b1;
        adcout     = '0;
        adcout_rep = '0;
        dump_start = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        sh_ext     = 1'b0;
        sh_ext_rep = 1'b0;
        sh_freeze  = 1'b0;
        sh_pi_ofs  = '0;
        m_prev     = 0;
        m_acc      = '0;
        lfsr_state = 32'h5ab1;
        err_cnt    = 0;
        for (int k = 0; k < NSLICE; k++) sh_ofs[k] = '0;
        for (int k = 0; k < 4; k++) m_err_pipe[k] = 0;

        repeat (8) @(posedge clk_adc);
        #1;
        reset_i = 1'b0;

        fd = $fopen("ti_rx_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open ti_rx_patterns.txt");
            err_cnt++;
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, " %c", cmd);
                if (n != 1) break;
                case (cmd)
                    "#": n = $fgets(line, fd);
                    "W": begin
                        n = $fscanf(fd, "%h %h", a, d);
                        host_write(REG_AW'(a), REG_DW'(d));
                    end
                    "R": begin
                        n = $fscanf(fd, "%h %h", a, d);
                        host_access(1'b0, REG_AW'(a), '0, rd);
                        check_reg($sformatf("host_rdata_o @%h", a), rd, REG_DW'(d));
                    end
                    "F": begin
                        n = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                        @(posedge clk_adc);
                        #1;
                        for (int k = 0; k < NTI; k++) adcout.mag[k] = NADC'(f[k]);
                        adcout.sign = NTI'(f[4]);
                        adcout_rep.mag[0] = NADC'(f[5]);
                        adcout_rep.mag[1] = NADC'(f[6]);
                        adcout_rep.sign = NTI_REP'(f[7]);
                    end
                    "E": begin
                        n = $fscanf(fd, "%h %h %h %h %h %h",
                                    f[0], f[1], f[2], f[3], f[4], f[5]);
                        repeat (3) @(posedge clk_adc);
                        #1;
                        for (int k = 0; k < NSLICE; k++) begin
                            exp_f[k] = sample_t'(f[k]);
                            check_sample($sformatf("unf_o[%0d]", k), unf[k], exp_f[k]);
                        end
                    end
                    "L": begin
                        n = $fscanf(fd, "%d", cycles);
                        run_cdr(cycles);
                    end
                    "D": run_dump();
                    "C": begin
                        n = $fscanf(fd, "%d", cycles);
                        repeat (cycles) @(posedge clk_adc);
                        #1;
                    end
                    default: begin
                        $display("Unknown pattern record %c", cmd);
                        err_cnt++;
                    end
                endcase
            end
            $fclose(fd);
        end

        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            fail_now();
        end
    end

endmodule

//--- ti_rx_patterns.txt
# W addr data | R addr expected | F mag0 mag1 mag2 mag3 signs rmag0 rmag1 rsigns
# E u0..u5 (9-bit hex) | L cycles (random CDR) | D (dump) | C cycles (hold), hex unless cycles
# CDR loop from reset, pi_offset set first
W 07 0123
L 200
# Freeze holds the code
W 00 0100
L 40
W 00 0000
# Register access
W 00 0155
R 00 0155
W 00 00f0
R 00 00a0
W 01 00ab
R 01 00ab
W 06 0055
R 06 0055
W 07 ffff
R 07 01ff
W 08 0005
R 08 0005
R 3f 0000
R 0e 0000
R 09 0000
W 00 0000
# External offsets per slice
W 01 0005
W 02 00fb
W 03 0010
W 04 0000
W 05 0020
W 06 00f0
W 00 000c
F 10 20 30 40 5 08 70 2
E 00b 1e5 020 1c0 1d8 080
# Saturation on replica slice 0
F ff 00 80 01 f ff fe 0
E 0fa 005 070 001 100 112
# Calibration on a constant input, navg 3
F 14 20 05 7f 5 30 0a 1
C 5
W 00 0033
C 30
R 10 003f
R 11 0014
R 12 ffe0
R 13 0005
R 14 ff81
R 15 0030
R 16 fff6
E 000 000 000 000 000 000
# One-shot dump with external offsets back on
W 00 000c
D
R 10 0080

//--- ti_rx_core.f
ti_rx_pkg.sv
ti_adc_retimer.sv
adc_unfolding.sv
mm_cdr.sv
oneshot_memory.sv
rx_cfg_regs.sv
ti_rx_core.sv
ti_rx_core_asserts.sv
tb_ti_rx_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ti_rx_core -f ti_rx_core.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    exit 1
fi
